// ==== logic/jpc_pkg.sv ====
//**********************************************************************
// shared types for the compressor front end
// pixel, coefficient, buffer address and count types, tile mode codes
//**********************************************************************
package jpc_pkg;

    // buffer geometry
    localparam int BUF_PAGES      = 4;  // macroblock pages in tile_buf
    localparam int WORDS_PER_PAGE = 32; // 64-bit words in one 16x16 macroblock

    // raw 8-bit pixel from the sensor path
    typedef logic [7:0] pixel_t;

    // pixel minus block average, fits -255..255
    typedef logic signed [8:0] coef_t;

    // write word, 8 pixels in scanline order
    typedef logic [63:0] buf_word_t;

    // page number inside the buffer
    typedef logic [1:0] page_t;

    // byte read address {page, byte index}
    typedef logic [9:0] buf_addr_t;

    // macroblocks per row or macroblock rows, minus 1
    typedef logic [12:0] mb_count_t;

    // 8x8 block inside a macroblock
    typedef logic [1:0] block_num_t;

    // tile modes, codes kept from the full compressor
    typedef enum logic [2:0] {
        cmprs_mono16 = 3'd2, // four quadrant blocks
        cmprs_jp4    = 3'd3  // one block per bayer plane
    } cmprs_mode_e;

endpackage

// ==== logic/tile_buf.sv ====
//**********************************************************************
// macroblock buffer, 64-bit word write side and byte read side
//**********************************************************************
module tile_buf #(
    parameter int N_PAGES = jpc_pkg::BUF_PAGES
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              frame_en,
    input  logic              buf_wr,
    input  jpc_pkg::buf_word_t buf_wdata,
    input  logic              rd_en,
    input  jpc_pkg::buf_addr_t rd_addr,
    output jpc_pkg::pixel_t   rd_data,
    output logic              page_written
);
    import jpc_pkg::*;

    localparam int WORD_W = $clog2(WORDS_PER_PAGE); // word index bits

    buf_word_t           mem [N_PAGES * WORDS_PER_PAGE]; // page-major word store
    logic [WORD_W-1:0]   wr_word;                        // word inside current page
    page_t               wr_page;                        // page being filled
    logic                last_word;                      // 32nd word of a page
    buf_word_t           rd_word;                        // addressed word
    logic [2:0]          rd_byte;                        // byte lane select

    assign last_word    = (wr_word == WORD_W'(WORDS_PER_PAGE - 1));
    assign page_written = buf_wr && frame_en && last_word; // same cycle as final write

    // write pointer walks words, then pages
    always_ff @(posedge clk) begin
        if (reset || !frame_en) begin
            wr_word <= '0;
            wr_page <= '0;
        end else if (buf_wr) begin
            wr_word <= wr_word + 1'b1; // wraps at page end
            if (last_word) begin
                if (wr_page == page_t'(N_PAGES - 1))
                    wr_page <= '0;
                else
                    wr_page <= wr_page + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (buf_wr && frame_en)
            mem[{wr_page, wr_word}] <= buf_wdata;
    end

    // read side, page and word from upper bits, byte from low 3
    assign rd_word = mem[rd_addr[$bits(buf_addr_t)-1:3]];
    assign rd_byte = rd_addr[2:0];

    always_ff @(posedge clk) begin
        if (rd_en)
            rd_data <= rd_word[rd_byte*8 +: 8]; // one cycle read latency
    end

endmodule

// ==== logic/mb_sequencer.sv ====
//**********************************************************************
// frame sequencer, page accounting and macroblock start
// tracks x/y position and marks first and last macroblock
//**********************************************************************
module mb_sequencer #(
    parameter int N_PAGES = jpc_pkg::BUF_PAGES
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               frame_en,
    input  logic               frame_go,
    input  jpc_pkg::mb_count_t n_blocks_in_row_m1,
    input  jpc_pkg::mb_count_t n_block_rows_m1,
    input  logic               page_written,
    input  logic               mb_done,
    output logic               mb_start,
    output jpc_pkg::page_t     rd_page,
    output logic               first_mb,
    output logic               last_mb,
    output logic               busy,
    output logic               buf_full
);
    import jpc_pkg::*;

    localparam int CNT_W = $clog2(N_PAGES + 1); // counts 0..N_PAGES

    typedef enum logic [1:0] {
        idle,
        wait_page,
        reading
    } seq_state_e;

    seq_state_e        state;
    logic [CNT_W-1:0]  n_filled;  // pages holding unread data
    mb_count_t         mb_x;      // next macroblock column
    mb_count_t         mb_y;      // next macroblock row
    logic              can_start; // launch a macroblock this cycle

    assign buf_full = (n_filled == CNT_W'(N_PAGES));

    // back to back launch when another page is already there
    always_comb begin
        can_start = 1'b0;
        if (state == wait_page)
            can_start = (n_filled != '0);
        else if (state == reading && mb_done && !last_mb)
            can_start = (n_filled > CNT_W'(1)) || page_written; // one page frees now
    end

    // page count runs even while idle so the source can prefill
    always_ff @(posedge clk) begin
        if (reset || !frame_en) begin
            n_filled <= '0;
            rd_page  <= '0;
        end else begin
            case ({page_written, mb_done})
                2'b10:   n_filled <= n_filled + 1'b1;
                2'b01:   n_filled <= n_filled - 1'b1;
                default: n_filled <= n_filled; // both or none
            endcase
            if (mb_done) begin
                if (rd_page == page_t'(N_PAGES - 1))
                    rd_page <= '0;
                else
                    rd_page <= rd_page + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || !frame_en) begin
            state    <= idle;
            busy     <= 1'b0;
            mb_start <= 1'b0;
            first_mb <= 1'b0;
            last_mb  <= 1'b0;
            mb_x     <= '0;
            mb_y     <= '0;
        end else begin
            mb_start <= can_start;
            if (can_start) begin
                first_mb <= (mb_x == '0) && (mb_y == '0);
                last_mb  <= (mb_x == n_blocks_in_row_m1) && (mb_y == n_block_rows_m1);
                if (mb_x == n_blocks_in_row_m1) begin
                    mb_x <= '0;
                    mb_y <= mb_y + 1'b1; // next macroblock row
                end else begin
                    mb_x <= mb_x + 1'b1;
                end
            end
            case (state)
                idle: if (frame_go) begin
                    state <= wait_page;
                    busy  <= 1'b1;
                    mb_x  <= '0;
                    mb_y  <= '0;
                end
                wait_page: if (can_start) state <= reading;
                reading: if (mb_done) begin
                    if (last_mb) begin
                        state <= idle; // frame done
                        busy  <= 1'b0;
                    end else if (!can_start) begin
                        state <= wait_page;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

// ==== logic/pixel_reader.sv ====
//**********************************************************************
// block-order address generator and pixel stream for one macroblock
//**********************************************************************
module pixel_reader (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 frame_en,
    input  jpc_pkg::cmprs_mode_e mode,
    input  logic                 mb_start,
    input  logic                 first_mb,
    input  logic                 last_mb,
    input  jpc_pkg::page_t       rd_page,
    output logic                 rd_en,
    output jpc_pkg::buf_addr_t   rd_addr,
    output logic                 mb_done,
    input  jpc_pkg::pixel_t      rd_data,
    output jpc_pkg::pixel_t      pix,
    output logic                 pix_valid,
    output logic                 blk_start,
    output jpc_pkg::block_num_t  blk_num,
    output logic                 blk_first,
    output logic                 blk_last
);
    import jpc_pkg::*;

    logic       active;  // macroblock read in progress
    logic [7:0] cnt;     // {block, row, column} read counter
    logic [7:0] idx;     // byte index inside the page
    page_t      page_l;  // page of the running macroblock
    logic       first_l; // flags latched at mb_start
    logic       last_l;

    // cnt[7:6] block, cnt[5:3] row in block, cnt[2:0] column
    always_comb begin
        case (mode)
            cmprs_jp4: idx = {cnt[5:3], cnt[7], cnt[2:0], cnt[6]}; // parity picks the plane
            default:   idx = {cnt[7], cnt[5:3], cnt[6], cnt[2:0]}; // quadrant of 16x16
        endcase
    end

    assign rd_en   = active;
    assign rd_addr = {page_l, idx};
    assign mb_done = active && (cnt == 8'hff); // last address of the macroblock
    assign pix     = rd_data;                  // buffer output register is the pixel stage

    always_ff @(posedge clk) begin
        if (reset || !frame_en) begin
            active <= 1'b0;
            cnt    <= '0;
        end else if (mb_start) begin
            active <= 1'b1;
            cnt    <= '0;
        end else if (active) begin
            cnt <= cnt + 1'b1;
            if (cnt == 8'hff)
                active <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (mb_start) begin
            page_l  <= rd_page;
            first_l <= first_mb;
            last_l  <= last_mb;
        end
    end

    // flags delayed one cycle to sit with rd_data
    always_ff @(posedge clk) begin
        if (reset || !frame_en) begin
            pix_valid <= 1'b0;
            blk_start <= 1'b0;
        end else begin
            pix_valid <= active;
            blk_start <= active && (cnt[5:0] == 6'd0);
        end
    end

    always_ff @(posedge clk) begin
        blk_num   <= cnt[7:6];
        blk_first <= first_l;
        blk_last  <= last_l;
    end

endmodule

// ==== logic/block_dc_remover.sv ====
//**********************************************************************
// double-buffered 8x8 block averager
// plays each block back with its rounded average removed
//**********************************************************************
module block_dc_remover (
    input  logic                clk,
    input  logic                reset,
    input  logic                frame_en,
    input  jpc_pkg::pixel_t     pix,
    input  logic                pix_valid,
    input  logic                blk_start,
    input  jpc_pkg::block_num_t blk_num,
    input  logic                blk_first,
    input  logic                blk_last,
    output jpc_pkg::coef_t      yc_nodc,
    output jpc_pkg::pixel_t     yc_avr,
    output logic                dv,
    output logic                ds,
    output jpc_pkg::block_num_t tn,
    output logic                first,
    output logic                last
);
    import jpc_pkg::*;

    pixel_t      mem [128];  // two 64-entry banks
    logic [5:0]  wa;         // write index of this pixel
    logic [5:0]  wcnt;       // next write index
    logic        wbank;      // bank being filled
    logic        wdone;      // block just completed
    logic [13:0] sum;        // running block sum
    logic [13:0] sum_rnd;    // sum plus half step
    block_num_t  tn_w;       // tags of the block being written
    logic        first_w;
    logic        last_w;
    logic        ractive;    // playback running
    logic        rbank;      // bank being played back
    logic [5:0]  rcnt;       // playback index
    pixel_t      rd_pix;

    assign wa      = blk_start ? 6'd0 : wcnt; // resync on every block start
    assign sum_rnd = sum + 14'd32;
    assign rd_pix  = mem[{rbank, rcnt}];

    always_ff @(posedge clk) begin
        if (pix_valid)
            mem[{wbank, wa}] <= pix;
    end

    // write side
    always_ff @(posedge clk) begin
        if (reset || !frame_en) begin
            wcnt  <= '0;
            wbank <= 1'b0;
            wdone <= 1'b0;
        end else begin
            wdone <= pix_valid && (wa == 6'd63);
            if (pix_valid) begin
                wcnt <= wa + 1'b1;
                if (wa == 6'd63)
                    wbank <= ~wbank; // swap banks at block end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pix_valid)
            sum <= (blk_start ? 14'd0 : sum) + 14'(pix);
        if (blk_start) begin
            tn_w    <= blk_num;
            first_w <= blk_first;
            last_w  <= blk_last;
        end
    end

    // playback control, ds one cycle ahead of dv
    always_ff @(posedge clk) begin
        if (reset || !frame_en) begin
            ractive <= 1'b0;
            rbank   <= 1'b0;
            rcnt    <= '0;
            ds      <= 1'b0;
            dv      <= 1'b0;
        end else begin
            ds <= wdone;
            dv <= ractive;
            if (wdone) begin
                ractive <= 1'b1;
                rbank   <= ~wbank; // bank that just filled
                rcnt    <= '0;
            end else if (ractive) begin
                rcnt <= rcnt + 1'b1;
                if (rcnt == 6'd63)
                    ractive <= 1'b0;
            end
        end
    end

    // average and tags held from ds to next ds
    always_ff @(posedge clk) begin
        if (wdone) begin
            yc_avr <= sum_rnd[13:6]; // (sum + 32) >> 6
            tn     <= tn_w;
            first  <= first_w;
            last   <= last_w;
        end
        if (ractive)
            yc_nodc <= $signed({1'b0, rd_pix}) - $signed({1'b0, yc_avr});
    end

endmodule

// ==== logic/jp_channel.sv ====
//**********************************************************************
// compressor channel front end, buffer to DC-removed blocks
//**********************************************************************
module jp_channel (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 frame_en,
    input  logic                 frame_go,
    input  logic                 buf_wr,
    input  jpc_pkg::buf_word_t   buf_wdata,
    input  jpc_pkg::mb_count_t   n_blocks_in_row_m1,
    input  jpc_pkg::mb_count_t   n_block_rows_m1,
    input  jpc_pkg::cmprs_mode_e mode,
    output logic                 busy,
    output logic                 buf_full,
    output jpc_pkg::coef_t       yc_nodc,
    output jpc_pkg::pixel_t      yc_avr,
    output logic                 dv,
    output logic                 ds,
    output jpc_pkg::block_num_t  tn,
    output logic                 first,
    output logic                 last
);
    import jpc_pkg::*;

    logic       page_written; // buffer to sequencer
    logic       mb_start;     // sequencer to reader
    page_t      rd_page;
    logic       first_mb;
    logic       last_mb;
    logic       mb_done;      // reader back to sequencer
    logic       rd_en;        // reader to buffer
    buf_addr_t  rd_addr;
    pixel_t     rd_data;
    pixel_t     pix;          // reader to DC remover
    logic       pix_valid;
    logic       blk_start;
    block_num_t blk_num;
    logic       blk_first;
    logic       blk_last;

    tile_buf #(.N_PAGES(BUF_PAGES)) tile_buf_i (
        .clk, .reset, .frame_en,
        .buf_wr, .buf_wdata,
        .rd_en, .rd_addr, .rd_data,
        .page_written
    );

    mb_sequencer #(.N_PAGES(BUF_PAGES)) mb_sequencer_i (
        .clk, .reset, .frame_en, .frame_go,
        .n_blocks_in_row_m1, .n_block_rows_m1,
        .page_written, .mb_done,
        .mb_start, .rd_page, .first_mb, .last_mb,
        .busy, .buf_full
    );

    pixel_reader pixel_reader_i (
        .clk, .reset, .frame_en, .mode,
        .mb_start, .first_mb, .last_mb, .rd_page,
        .rd_en, .rd_addr, .mb_done, .rd_data,
        .pix, .pix_valid, .blk_start, .blk_num,
        .blk_first, .blk_last
    );

    block_dc_remover block_dc_remover_i (
        .clk, .reset, .frame_en,
        .pix, .pix_valid, .blk_start, .blk_num,
        .blk_first, .blk_last,
        .yc_nodc, .yc_avr, .dv, .ds, .tn, .first, .last
    );

endmodule

// ==== test/tb_jp_channel.sv ====
//**********************************************************************
// testbench for the channel front end with LFSR pixel frames and a block model
// checks DC-removed blocks, flags, back-pressure and frame abort
//**********************************************************************
module tb_jp_channel;
    import jpc_pkg::*;

    localparam int TIMEOUT = 4000; // cycles allowed in any wait loop

    logic        clk = 1'b0;
    logic        reset;
    logic        frame_en;
    logic        frame_go;
    logic        buf_wr;
    buf_word_t   buf_wdata;
    mb_count_t   n_blocks_in_row_m1;
    mb_count_t   n_block_rows_m1;
    cmprs_mode_e mode;
    logic        busy, buf_full, dv, ds, first, last;
    coef_t       yc_nodc;
    pixel_t      yc_avr;
    block_num_t  tn;

    pixel_t      ref_px [2048];  // frame pixels, 256 per macroblock
    coef_t       exp_val [$];    // expected yc_nodc stream
    pixel_t      exp_avr [$];    // per block from here on
    block_num_t  exp_tn [$];
    logic        exp_first [$];
    logic        exp_last [$];
    logic [15:0] lfsr = 16'd75;
    string       test_name;
    int          errors, checks, passed, failed, err_mark;
    int          dv_cnt;         // dv cycles of the open block
    int          n_first, n_last; // blocks seen with each flag
    int          frame_mbs;      // macroblocks in the current frame
    logic        blk_open;       // ds seen, dv run not yet closed

    jp_channel dut_i (
        .clk, .reset, .frame_en, .frame_go, .buf_wr, .buf_wdata,
        .n_blocks_in_row_m1, .n_block_rows_m1, .mode,
        .busy, .buf_full, .yc_nodc, .yc_avr, .dv, .ds, .tn, .first, .last
    );

    always #20 clk = ~clk;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // x^16+x^14+x^13+x^11+1
    endfunction

    task automatic get_byte(output pixel_t b);
        b = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_next(lfsr);
            b    = {b[6:0], lfsr[0]}; // one step per bit
        end
    endtask

    // where pixel (r, c) of block k sits in the 16x16 macroblock
    function automatic int pix_pos(cmprs_mode_e m, int k, int r, int c);
        int row;
        int col;
        if (m == cmprs_jp4) begin
            row = 2 * r + k / 2; // bayer plane by row/column parity
            col = 2 * c + k % 2;
        end else begin
            row = 8 * (k / 2) + r; // quadrant
            col = 8 * (k % 2) + c;
        end
        return 16 * row + col;
    endfunction

    task automatic report_error(string msg);
        errors++;
        $display("%s: %s", test_name, msg);
    endtask

    task automatic report_mismatch(string what, int exp_v, int act_v);
        errors++;
        $display("Mismatch %s %s: expected %0d actual %0d", test_name, what, exp_v, act_v);
    endtask

    // random pixels and the expected blocks of a whole frame
    task automatic make_frame(cmprs_mode_e m, int n_mb);
        int     sum;
        int     avr;
        int     v;
        pixel_t p;
        for (int i = 0; i < 256 * n_mb; i++) begin
            get_byte(p);
            ref_px[i] = p;
        end
        for (int mb = 0; mb < n_mb; mb++)
            for (int k = 0; k < 4; k++) begin
                sum = 0;
                for (int i = 0; i < 64; i++)
                    sum += ref_px[256 * mb + pix_pos(m, k, i / 8, i % 8)];
                avr = (sum + 32) / 64; // rounded average
                exp_avr.push_back(pixel_t'(avr));
                exp_tn.push_back(block_num_t'(k));
                exp_first.push_back(mb == 0);
                exp_last.push_back(mb == n_mb - 1);
                for (int i = 0; i < 64; i++) begin
                    v = ref_px[256 * mb + pix_pos(m, k, i / 8, i % 8)];
                    exp_val.push_back(coef_t'(v - avr));
                end
            end
    endtask

    task automatic clear_expected();
        exp_val.delete();
        exp_avr.delete();
        exp_tn.delete();
        exp_first.delete();
        exp_last.delete();
        blk_open = 1'b0;
        dv_cnt   = 0;
        n_first  = 0;
        n_last   = 0;
    endtask

    // one macroblock of 32 words started only while buf_full is low
    task automatic write_page(int mb);
        int wait_cnt;
        wait_cnt = 0;
        while (buf_full && wait_cnt < TIMEOUT) begin
            @(posedge clk);
            #2;
            wait_cnt++;
        end
        if (buf_full)
            report_error($sformatf("timeout, buf_full stayed high before page %0d", mb));
        for (int w = 0; w < 32; w++) begin
            buf_wr = 1'b1;
            for (int i = 0; i < 8; i++)
                buf_wdata[8 * i +: 8] = ref_px[256 * mb + 8 * w + i]; // pixel 8w+i
            @(posedge clk);
            #2;
        end
        buf_wr = 1'b0;
    endtask

    task automatic pulse_go();
        frame_go = 1'b1;
        @(posedge clk);
        #2;
        frame_go = 1'b0;
    endtask

    task automatic setup_frame(cmprs_mode_e m, int nx_m1, int ny_m1);
        mode               = m;
        n_blocks_in_row_m1 = mb_count_t'(nx_m1);
        n_block_rows_m1    = mb_count_t'(ny_m1);
        frame_mbs          = (nx_m1 + 1) * (ny_m1 + 1);
        make_frame(m, frame_mbs);
    endtask

    function automatic logic frame_pending();
        return busy || exp_val.size() != 0 || (blk_open && dv_cnt < 64);
    endfunction

    task automatic wait_frame_end();
        int wait_cnt;
        wait_cnt = 0;
        while (frame_pending() && wait_cnt < TIMEOUT) begin
            @(posedge clk);
            #2;
            wait_cnt++;
        end
        if (frame_pending())
            report_error("timeout, frame did not finish or blocks are missing");
        repeat (4) @(posedge clk); // stray dv trips the checker
        #2;
        checks++;
        assert (n_first == 4 && n_last == 4)
            else report_error($sformatf("first on %0d blocks, last on %0d, 4 each expected",
                                        n_first, n_last));
    endtask

    task automatic run_frame(cmprs_mode_e m, int nx_m1, int ny_m1);
        setup_frame(m, nx_m1, ny_m1);
        pulse_go();
        for (int mb = 0; mb < frame_mbs; mb++)
            write_page(mb);
        wait_frame_end();
    endtask

    task automatic begin_test(string name);
        test_name = name;
        err_mark  = errors;
        n_first   = 0;
        n_last    = 0;
    endtask

    task automatic end_test();
        if (errors == err_mark) begin
            passed++;
            $display("%s: pass", test_name);
        end else begin
            failed++;
            $display("%s: fail, %0d errors", test_name, errors - err_mark);
        end
    endtask

    // output checker on the falling edge compares dv values with the queue head
    always @(negedge clk) begin
        if (!reset && frame_en) begin
            if (blk_open && dv_cnt < 64 && !dv) begin
                report_error($sformatf("dv dropped after %0d cycles of a block", dv_cnt));
                blk_open = 1'b0;
            end
            if (dv) begin
                if (!blk_open || dv_cnt >= 64 || exp_val.size() == 0) begin
                    report_error("dv high outside a 64-cycle block");
                end else begin
                    checks++;
                    assert (yc_nodc == exp_val[0])
                        else report_mismatch("yc_nodc", exp_val[0], yc_nodc);
                    void'(exp_val.pop_front());
                    dv_cnt++;
                end
            end
            if (ds) begin
                if (blk_open && dv_cnt != 64)
                    report_error($sformatf("block ran %0d dv cycles, 64 expected", dv_cnt));
                if (exp_avr.size() == 0) begin
                    report_error("ds with no block expected");
                    blk_open = 1'b0;
                end else begin
                    checks++;
                    assert (yc_avr == exp_avr[0])
                        else report_mismatch("yc_avr", exp_avr[0], yc_avr);
                    assert (tn == exp_tn[0]) else report_mismatch("tn", exp_tn[0], tn);
                    assert (first == exp_first[0])
                        else report_mismatch("first", exp_first[0], first);
                    assert (last == exp_last[0]) else report_mismatch("last", exp_last[0], last);
                    n_first += first;
                    n_last  += last;
                    void'(exp_avr.pop_front());
                    void'(exp_tn.pop_front());
                    void'(exp_first.pop_front());
                    void'(exp_last.pop_front());
                    blk_open = 1'b1;
                    dv_cnt   = 0;
                end
            end
        end
    end

    initial begin
        int wait_cnt;
        reset              = 1'b1;
        frame_en           = 1'b0;
        frame_go           = 1'b0;
        buf_wr             = 1'b0;
        buf_wdata          = '0;
        n_blocks_in_row_m1 = '0;
        n_block_rows_m1    = '0;
        mode               = cmprs_mono16;
        {errors, checks, passed, failed, err_mark} = '0;
        clear_expected();
        test_name = "reset";
        repeat (4) @(posedge clk);
        #2;
        reset    = 1'b0;
        frame_en = 1'b1;

        begin_test("idle_after_reset");
        repeat (20) begin
            checks++;
            assert (!busy && !buf_full && !dv && !ds)
                else report_error("busy, buf_full, dv or ds high with no frame running");
            @(posedge clk);
            #2;
        end
        end_test();

        begin_test("mono16_2x2");
        run_frame(cmprs_mono16, 1, 1);
        end_test();

        begin_test("jp4_3x1");
        run_frame(cmprs_jp4, 2, 0);
        end_test();

        begin_test("flags_and_block_length");
        run_frame(cmprs_mono16, 0, 2); // one column of three rows
        end_test();

        begin_test("back_pressure");
        setup_frame(cmprs_mono16, 2, 1); // 6 macroblocks over 4 pages
        for (int mb = 0; mb < 4; mb++)
            write_page(mb);
        checks++;
        assert (buf_full && !busy) else report_error("buf_full low after four prefilled pages");
        pulse_go();
        for (int mb = 4; mb < frame_mbs; mb++)
            write_page(mb); // waits for buf_full to fall
        wait_frame_end();
        end_test();

        begin_test("frame_abort");
        setup_frame(cmprs_jp4, 1, 1);
        pulse_go();
        write_page(0);
        write_page(1);
        wait_cnt = 0;
        while (!(dv && !first) && wait_cnt < TIMEOUT) begin // reader on the second page
            @(posedge clk);
            #2;
            wait_cnt++;
        end
        if (!(dv && !first))
            report_error("timeout, second macroblock never reached dv");
        frame_en = 1'b0;
        @(posedge clk);
        #2;
        clear_expected(); // rest of the aborted frame never comes
        checks++;
        assert (!busy && !dv && !ds) else report_error("busy, dv or ds high with frame_en low");
        @(posedge clk);
        #2;
        frame_en = 1'b1;
        run_frame(cmprs_mono16, 1, 0);
        end_test();

        $display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
                 passed + failed, passed, failed, checks, errors);
        if (errors == 0 && failed == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== vlog.f ====
logic/jpc_pkg.sv
logic/tile_buf.sv
logic/mb_sequencer.sv
logic/pixel_reader.sv
logic/block_dc_remover.sv
logic/jp_channel.sv
test/tb_jp_channel.sv

// ==== Bender.yml ====
package:
  name: jp_channel

sources:
  - files:
      - logic/jpc_pkg.sv
      - logic/tile_buf.sv
      - logic/mb_sequencer.sv
      - logic/pixel_reader.sv
      - logic/block_dc_remover.sv
      - logic/jp_channel.sv
  - target: test
    files:
      - test/tb_jp_channel.sv
